// File: rtl/sched_defs.svh
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// Core and slot pool sizes
`define CORE_COUNT      16
`define SLOT_COUNT      16
`define SLOT_WIDTH      5
`define CORE_ID_WIDTH   4

// Control message layout
`define CTRL_WIDTH      36
`define MSG_TYPE_WIDTH  4
`define MSG_TYPE_LSB    32
`define SLOT_FIELD_LSB  16

// Host command layout
`define HOST_WR_BIT     31
`define HOST_SCHED_BIT  29
`define HOST_CORE_LSB   4
`define HOST_RD_DEFAULT 32'hFEFEFEFE

`endif

// File: rtl/sched_pkg.sv
`default_nettype none

`include "sched_defs.svh"

package sched_pkg;

  typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;

  // Slot numbers run 1 to SLOT_COUNT, so zero is never a valid slot
  typedef logic [`SLOT_WIDTH-1:0] slot_t;

  typedef logic [`SLOT_WIDTH-1:0] slot_count_t;

  typedef logic [`CORE_COUNT-1:0] core_mask_t;

  typedef enum logic {
    KEEP_IDLE,
    KEEP_FILL
  } keeper_state_e;

endpackage

`default_nettype wire

// File: rtl/ctrl_msg_pkg.sv
`default_nettype none

`include "sched_defs.svh"

package ctrl_msg_pkg;

  typedef logic [`CTRL_WIDTH-1:0] ctrl_data_t;

  // Other type codes are ignored by the decoder
  typedef enum logic [`MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN = 4'd0,
    MSG_SLOT_INIT   = 4'd3
  } msg_type_e;

  typedef logic [31:0] host_word_t;

  // Register address in host command bits 3 to 0
  typedef enum logic [3:0] {
    HOST_ENABLE     = 4'd0,
    HOST_INCOME     = 4'd1,
    HOST_FLUSH      = 4'd2,
    HOST_SLOT_COUNT = 4'd3,
    HOST_ERRORS     = 4'd4
  } host_addr_e;

endpackage

`default_nettype wire

// File: rtl/host_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module host_cmd_regs (
  input  wire                                         clk,
  input  wire                                         rst_r,
  input  wire ctrl_msg_pkg::host_word_t               host_cmd,
  input  wire ctrl_msg_pkg::host_word_t               host_cmd_wr_data,
  input  wire                                         host_cmd_valid,
  input  wire sched_pkg::slot_count_t [`CORE_COUNT-1:0] counts,
  input  wire sched_pkg::core_mask_t                  enq_errs,
  output ctrl_msg_pkg::host_word_t                    host_cmd_rd_data,
  output sched_pkg::core_mask_t                       enabled_cores,
  output sched_pkg::core_mask_t                       income_cores,
  output sched_pkg::core_mask_t                       flush
);

  import sched_pkg::*;
  import ctrl_msg_pkg::*;

  logic       wr_r;
  host_addr_e addr_r;
  core_id_t   core_r;
  host_word_t wr_data_r;
  host_word_t rd_data_r;
  core_mask_t wr_mask;

  assign wr_mask = wr_data_r[`CORE_COUNT-1:0];

  // First stage registers the command fields
  always_ff @(posedge clk) begin
    addr_r    <= host_addr_e'(host_cmd[3:0]);
    core_r    <= host_cmd[`HOST_CORE_LSB +: `CORE_ID_WIDTH];
    wr_data_r <= host_cmd_wr_data;
  end

  // Writes need both the write bit and the scheduler select bit
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      flush         <= '0;
    end else begin
      wr_r  <= host_cmd_valid && host_cmd[`HOST_WR_BIT] && host_cmd[`HOST_SCHED_BIT];
      flush <= '0;
      if (wr_r) begin
        case (addr_r)
          HOST_ENABLE: begin
            // A disabled core cannot stay an income core
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          HOST_INCOME: begin
            income_cores <= wr_mask & enabled_cores;
          end
          HOST_FLUSH: begin
            flush <= wr_mask;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read mux, then an output register
  always_ff @(posedge clk) begin
    case (addr_r)
      HOST_ENABLE:     rd_data_r <= host_word_t'(enabled_cores);
      HOST_INCOME:     rd_data_r <= host_word_t'(income_cores);
      HOST_SLOT_COUNT: rd_data_r <= host_word_t'(counts[core_r]);
      HOST_ERRORS:     rd_data_r <= host_word_t'(enq_errs);
      default:         rd_data_r <= `HOST_RD_DEFAULT;
    endcase
    host_cmd_rd_data <= rd_data_r;
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_msg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module ctrl_msg_decoder (
  input  wire                          clk,
  input  wire                          rst_r,
  input  wire                          ctrl_valid,
  input  wire ctrl_msg_pkg::ctrl_data_t ctrl_data,
  input  wire sched_pkg::core_id_t     ctrl_src,
  output sched_pkg::core_mask_t        init_strobe,
  output sched_pkg::core_mask_t        return_strobe,
  output sched_pkg::slot_t             msg_slot
);

  import sched_pkg::*;
  import ctrl_msg_pkg::*;

  msg_type_e msg_type;

  assign msg_type = msg_type_e'(ctrl_data[`MSG_TYPE_LSB +: `MSG_TYPE_WIDTH]);

  // One strobe bit for the source core, registered for timing
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_strobe   <= '0;
      return_strobe <= '0;
    end else begin
      init_strobe   <= '0;
      return_strobe <= '0;
      if (ctrl_valid) begin
        case (msg_type)
          MSG_SLOT_INIT:   init_strobe[ctrl_src]   <= 1'b1;
          MSG_SLOT_RETURN: return_strobe[ctrl_src] <= 1'b1;
          default: begin
          end
        endcase
      end
    end
  end

  // Slot number for a return, slot count for an init
  always_ff @(posedge clk) begin
    msg_slot <= ctrl_data[`SLOT_FIELD_LSB +: `SLOT_WIDTH];
  end

  // At most one keeper is told anything per cycle
  a_single_strobe: assert property (
    @(posedge clk) disable iff (rst_r)
    $onehot0(init_strobe) && $onehot0(return_strobe) &&
    !((|init_strobe) && (|return_strobe))
  );

endmodule

`default_nettype wire

// File: rtl/slot_keeper.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module slot_keeper (
  input  wire                    clk,
  input  wire                    rst_r,
  input  wire                    flush,
  input  wire                    init_strobe,
  input  wire                    return_strobe,
  input  wire                    pop,
  input  wire sched_pkg::slot_t  msg_slot,
  output sched_pkg::slot_t       head_slot,
  output logic                   head_valid,
  output sched_pkg::slot_count_t count,
  output logic                   enq_err
);

  import sched_pkg::*;

  localparam int PTR_WIDTH = $clog2(`SLOT_COUNT);

  keeper_state_e        state;
  slot_t                mem [`SLOT_COUNT];
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr;
  slot_t                fill_next;
  slot_count_t          fill_target;
  logic                 full;
  logic                 push;
  logic                 take;
  slot_t                push_slot;

  assign full = (count == `SLOT_COUNT);
  assign take = pop && head_valid;

  // Fill pushes the next slot number, otherwise an accepted return
  assign push      = (state == KEEP_FILL) || (return_strobe && (state == KEEP_IDLE) && !full);
  assign push_slot = (state == KEEP_FILL) ? fill_next : msg_slot;

  assign head_slot  = mem[rd_ptr];
  assign head_valid = (state == KEEP_IDLE) && (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      state       <= KEEP_IDLE;
      rd_ptr      <= '0;
      wr_ptr      <= '0;
      count       <= '0;
      fill_next   <= slot_t'(1);
      fill_target <= '0;
      enq_err     <= 1'b0;
    end else if (init_strobe) begin
      // Init empties the pool and refills it with slots 1 to n
      rd_ptr      <= '0;
      wr_ptr      <= '0;
      count       <= '0;
      fill_next   <= slot_t'(1);
      fill_target <= (msg_slot > `SLOT_COUNT) ? slot_count_t'(`SLOT_COUNT) : msg_slot;
      state       <= (msg_slot == '0) ? KEEP_IDLE : KEEP_FILL;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !take) begin
        count <= count + 1'b1;
      end else if (take && !push) begin
        count <= count - 1'b1;
      end
      if (state == KEEP_FILL) begin
        fill_next <= fill_next + 1'b1;
        if (fill_next == fill_target) begin
          state <= KEEP_IDLE;
        end
      end
      // Dropped return, sticky until flush
      if (return_strobe && ((state == KEEP_FILL) || full)) begin
        enq_err <= 1'b1;
      end
    end
  end

  a_pop_has_head: assert property (
    @(posedge clk) disable iff (rst_r) pop |-> head_valid
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst_r) count <= `SLOT_COUNT
  );

endmodule

`default_nettype wire

// File: rtl/core_selector.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module core_selector (
  input  wire                                           clk,
  input  wire                                           rst_r,
  input  wire                                           alloc_req,
  input  wire sched_pkg::core_mask_t                    income_cores,
  input  wire sched_pkg::slot_count_t [`CORE_COUNT-1:0] counts,
  input  wire sched_pkg::slot_t [`CORE_COUNT-1:0]       head_slots,
  input  wire sched_pkg::core_mask_t                    head_valids,
  output sched_pkg::core_mask_t                         pop,
  output logic                                          alloc_grant,
  output sched_pkg::core_id_t                           alloc_core,
  output sched_pkg::slot_t                              alloc_slot
);

  import sched_pkg::*;

  core_mask_t  nonzero;
  core_mask_t  eligible;
  logic        best_valid;
  core_id_t    best_core;
  slot_count_t best_count;
  logic        take;

  always_comb begin
    for (int i = 0; i < `CORE_COUNT; i++) begin
      nonzero[i] = (counts[i] != '0);
    end
  end

  assign eligible = income_cores & head_valids & nonzero;

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best_valid = 1'b0;
    best_core  = '0;
    best_count = '0;
    for (int i = 0; i < `CORE_COUNT; i++) begin
      if (eligible[i] && (!best_valid || (counts[i] > best_count))) begin
        best_valid = 1'b1;
        best_core  = core_id_t'(i);
        best_count = counts[i];
      end
    end
  end

  assign take = alloc_req && best_valid;
  assign pop  = take ? (core_mask_t'(1) << best_core) : '0;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      alloc_grant <= 1'b0;
    end else begin
      alloc_grant <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      alloc_core <= best_core;
      alloc_slot <= head_slots[best_core];
    end
  end

  // Income mask as it stood on the popping edge
  a_grant_income: assert property (
    @(posedge clk) disable iff (rst_r)
    alloc_grant |-> |($past(income_cores) & (core_mask_t'(1) << alloc_core))
  );

endmodule

`default_nettype wire

// File: rtl/sched_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module sched_top (
  input  wire                           clk,
  input  wire                           rst_r,
  input  wire                           ctrl_valid,
  input  wire ctrl_msg_pkg::ctrl_data_t ctrl_data,
  input  wire sched_pkg::core_id_t      ctrl_src,
  input  wire ctrl_msg_pkg::host_word_t host_cmd,
  input  wire ctrl_msg_pkg::host_word_t host_cmd_wr_data,
  input  wire                           host_cmd_valid,
  output ctrl_msg_pkg::host_word_t      host_cmd_rd_data,
  input  wire                           alloc_req,
  output logic                          alloc_grant,
  output sched_pkg::core_id_t           alloc_core,
  output sched_pkg::slot_t              alloc_slot
);

  import sched_pkg::*;

  wire core_mask_t                    init_strobe;
  wire core_mask_t                    return_strobe;
  wire slot_t                         msg_slot;
  wire slot_count_t [`CORE_COUNT-1:0] counts;
  wire slot_t [`CORE_COUNT-1:0]       head_slots;
  wire core_mask_t                    head_valids;
  wire core_mask_t                    enq_errs;
  wire core_mask_t                    pop;
  wire core_mask_t                    flush;
  wire core_mask_t                    income_cores;

  ctrl_msg_decoder u_decoder (
    .clk           (clk),
    .rst_r         (rst_r),
    .ctrl_valid    (ctrl_valid),
    .ctrl_data     (ctrl_data),
    .ctrl_src      (ctrl_src),
    .init_strobe   (init_strobe),
    .return_strobe (return_strobe),
    .msg_slot      (msg_slot)
  );

  for (genvar i = 0; i < `CORE_COUNT; i++) begin : g_keeper
    slot_keeper u_keeper (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (flush[i]),
      .init_strobe   (init_strobe[i]),
      .return_strobe (return_strobe[i]),
      .pop           (pop[i]),
      .msg_slot      (msg_slot),
      .head_slot     (head_slots[i]),
      .head_valid    (head_valids[i]),
      .count         (counts[i]),
      .enq_err       (enq_errs[i])
    );
  end

  core_selector u_selector (
    .clk          (clk),
    .rst_r        (rst_r),
    .alloc_req    (alloc_req),
    .income_cores (income_cores),
    .counts       (counts),
    .head_slots   (head_slots),
    .head_valids  (head_valids),
    .pop          (pop),
    .alloc_grant  (alloc_grant),
    .alloc_core   (alloc_core),
    .alloc_slot   (alloc_slot)
  );

  // The enabled mask is only needed inside the host registers
  host_cmd_regs u_host_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .counts           (counts),
    .enq_errs         (enq_errs),
    .host_cmd_rd_data (host_cmd_rd_data),
    .enabled_cores    (),
    .income_cores     (income_cores),
    .flush            (flush)
  );

endmodule

`default_nettype wire

// File: sim/sched_tests.svh
`ifndef SCHED_TESTS_SVH
`define SCHED_TESTS_SVH

// Free slots per core and the next slot a fresh pool hands out
int    pool_left [`CORE_COUNT];
slot_t pool_next [`CORE_COUNT];

// Inputs change 1 ns after the rising edge
task automatic tick();
  @(posedge clk);
  #1;
endtask

task automatic host_write(input logic [3:0] addr, input core_mask_t data);
  host_cmd         = {4'hA, 24'h0, addr};
  host_cmd_wr_data = host_word_t'(data);
  host_cmd_valid   = 1'b1;
  tick();
  host_cmd_valid   = 1'b0;
  // Write lands on the following edge
  tick();
endtask

task automatic host_read(input logic [3:0] addr, input core_id_t core, output host_word_t data);
  host_cmd       = {4'h2, 20'h0, core, addr};
  host_cmd_valid = 1'b1;
  tick();
  host_cmd_valid = 1'b0;
  repeat (2) tick();
  data = host_cmd_rd_data;
endtask

task automatic send_msg(input core_id_t src, input msg_type_e kind, input slot_t slot);
  ctrl_data = '0;
  ctrl_data[`MSG_TYPE_LSB +: `MSG_TYPE_WIDTH] = kind;
  ctrl_data[`SLOT_FIELD_LSB +: `SLOT_WIDTH]   = slot;
  ctrl_src   = src;
  ctrl_valid = 1'b1;
  tick();
  ctrl_valid = 1'b0;
endtask

task automatic init_pool(input core_id_t core, input slot_t n);
  send_msg(core, MSG_SLOT_INIT, n);
  pool_left[core] = int'(n);
  pool_next[core] = slot_t'(1);
endtask

task automatic wait_grant(input int max_cycles);
  int waited;
  waited = 0;
  tick();
  while (!alloc_grant) begin
    if (waited >= max_cycles) begin
      $display("No allocation grant within %0d cycles at %0t", max_cycles, $time);
      abort_run();
    end
    waited++;
    tick();
  end
endtask

task automatic expect_no_grant(input int cycles);
  repeat (cycles) begin
    tick();
    if (alloc_grant) begin
      $display("Unexpected grant to core %0d at %0t with no eligible core", alloc_core, $time);
      abort_run();
    end
  end
endtask

// Most free slots wins, lowest index on a tie
function automatic core_id_t pick_core(input core_mask_t income);
  core_id_t best;
  int       best_left;
  best      = '0;
  best_left = 0;
  for (int i = 0; i < `CORE_COUNT; i++) begin
    if (income[i] && (pool_left[i] > best_left)) begin
      best      = core_id_t'(i);
      best_left = pool_left[i];
    end
  end
  return best;
endfunction

task automatic take_grant(input core_mask_t income);
  core_id_t exp_core;
  exp_core = pick_core(income);
  wait_grant(16);
  check_core("alloc_core", alloc_core, exp_core);
  check_slot("alloc_slot", alloc_slot, pool_next[exp_core]);
  pool_left[exp_core]--;
  pool_next[exp_core]++;
endtask

task automatic reset_state_test();
  host_word_t rd;
  host_read(HOST_ENABLE, '0, rd);
  check_word("enabled_cores", rd, '0);
  host_read(HOST_INCOME, '0, rd);
  check_word("income_cores", rd, '0);
  for (int i = 0; i < `CORE_COUNT; i += 5) begin
    host_read(HOST_SLOT_COUNT, core_id_t'(i), rd);
    check_word("slot count", rd, '0);
  end
  host_read(HOST_ERRORS, '0, rd);
  check_word("enq_errs", rd, '0);
  alloc_req = 1'b1;
  expect_no_grant(8);
  alloc_req = 1'b0;
  host_read(4'hB, '0, rd);
  check_word("unknown address read", rd, `HOST_RD_DEFAULT);
endtask

task automatic income_mask_test();
  host_word_t rd;
  core_mask_t en;
  core_mask_t inc;
  core_mask_t en2;
  en  = core_mask_t'($urandom);
  inc = core_mask_t'($urandom);
  en2 = core_mask_t'($urandom);
  host_write(HOST_ENABLE, en);
  host_write(HOST_INCOME, inc);
  host_read(HOST_ENABLE, '0, rd);
  check_word("enabled_cores", rd, host_word_t'(en));
  host_read(HOST_INCOME, '0, rd);
  check_word("income_cores", rd, host_word_t'(en & inc));
  // Disabled cores drop out of the income mask
  host_write(HOST_ENABLE, en2);
  host_read(HOST_INCOME, '0, rd);
  check_word("income_cores", rd, host_word_t'(en & inc & en2));
endtask

task automatic grant_order_test();
  host_word_t rd;
  core_mask_t income;
  core_id_t   core_a;
  core_id_t   core_b;
  core_a = 4'd2;
  core_b = 4'd7;
  income = (core_mask_t'(1) << core_a) | (core_mask_t'(1) << core_b);
  host_write(HOST_ENABLE, income);
  host_write(HOST_INCOME, income);
  init_pool(core_a, 5'd3);
  init_pool(core_b, 5'd5);
  repeat (8) tick();
  host_read(HOST_SLOT_COUNT, core_b, rd);
  check_word("slot count", rd, 32'd5);
  alloc_req = 1'b1;
  repeat (8) take_grant(income);
  expect_no_grant(6);
  alloc_req = 1'b0;
endtask

task automatic slot_return_test();
  host_word_t rd;
  slot_t      returned[$];
  slot_t      slot;
  core_id_t   core_c;
  core_c = 4'd5;
  host_write(HOST_ENABLE, core_mask_t'(1) << core_c);
  host_write(HOST_INCOME, core_mask_t'(1) << core_c);
  for (int i = 1; i <= 4; i++) begin
    slot = slot_t'(($urandom % `SLOT_COUNT) + 1);
    returned.push_back(slot);
    send_msg(core_c, MSG_SLOT_RETURN, slot);
    host_read(HOST_SLOT_COUNT, core_c, rd);
    check_word("slot count", rd, host_word_t'(i));
  end
  alloc_req = 1'b1;
  while (returned.size() > 0) begin
    wait_grant(16);
    check_core("alloc_core", alloc_core, core_c);
    check_slot("alloc_slot", alloc_slot, returned.pop_front());
  end
  expect_no_grant(4);
  alloc_req = 1'b0;
endtask

task automatic overflow_flush_test();
  host_word_t rd;
  core_id_t   core_d;
  core_d = 4'd9;
  init_pool(core_d, slot_t'(`SLOT_COUNT));
  repeat (`SLOT_COUNT + 2) tick();
  host_read(HOST_SLOT_COUNT, core_d, rd);
  check_word("slot count", rd, 32'd16);
  // One slot more than a full pool holds
  send_msg(core_d, MSG_SLOT_RETURN, 5'd4);
  host_read(HOST_ERRORS, '0, rd);
  check_word("enq_errs", rd, host_word_t'(core_mask_t'(1) << core_d));
  host_read(HOST_SLOT_COUNT, core_d, rd);
  check_word("slot count", rd, 32'd16);
  host_write(HOST_FLUSH, core_mask_t'(1) << core_d);
  pool_left[core_d] = 0;
  host_read(HOST_SLOT_COUNT, core_d, rd);
  check_word("slot count", rd, '0);
  host_read(HOST_ERRORS, '0, rd);
  check_word("enq_errs", rd, '0);
endtask

task automatic income_exclusion_test();
  host_word_t rd;
  core_id_t   core_e;
  core_id_t   core_f;
  core_e = 4'd3;
  core_f = 4'd12;
  host_write(HOST_ENABLE, (core_mask_t'(1) << core_e) | (core_mask_t'(1) << core_f));
  host_write(HOST_INCOME, core_mask_t'(1) << core_f);
  init_pool(core_e, 5'd10);
  init_pool(core_f, 5'd4);
  repeat (12) tick();
  alloc_req = 1'b1;
  repeat (4) take_grant(core_mask_t'(1) << core_f);
  // Core E keeps its ten slots but is not an income core
  expect_no_grant(8);
  alloc_req = 1'b0;
  host_read(HOST_SLOT_COUNT, core_e, rd);
  check_word("slot count", rd, 32'd10);
endtask

`endif

// File: sim/tb_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_defs.svh"

module tb_sched_top;

  import sched_pkg::*;
  import ctrl_msg_pkg::*;

  // The six tests take a few hundred cycles together
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] RAND_SEED      = 32'h66367f2f;

  logic       clk;
  logic       rst_r;
  logic       ctrl_valid;
  ctrl_data_t ctrl_data;
  core_id_t   ctrl_src;
  host_word_t host_cmd;
  host_word_t host_cmd_wr_data;
  logic       host_cmd_valid;
  host_word_t host_cmd_rd_data;
  logic       alloc_req;
  logic       alloc_grant;
  core_id_t   alloc_core;
  slot_t      alloc_slot;
  int         cycle_count = 0;

  sched_top uut (
    .clk              (clk),
    .rst_r            (rst_r),
    .ctrl_valid       (ctrl_valid),
    .ctrl_data        (ctrl_data),
    .ctrl_src         (ctrl_src),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .alloc_req        (alloc_req),
    .alloc_grant      (alloc_grant),
    .alloc_core       (alloc_core),
    .alloc_slot       (alloc_slot)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_core(input string name, input core_id_t got, input core_id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_slot(input string name, input slot_t got, input slot_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  `include "sched_tests.svh"

  initial begin
    clk              = 1'b0;
    rst_r            = 1'b1;
    ctrl_valid       = 1'b0;
    ctrl_data        = '0;
    ctrl_src         = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    alloc_req        = 1'b0;
    void'($urandom(RAND_SEED));
    repeat (4) @(posedge clk);
    #1;
    rst_r = 1'b0;
    reset_state_test();
    income_mask_test();
    grant_order_test();
    slot_return_test();
    overflow_flush_test();
    income_exclusion_test();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
+incdir+sim
rtl/sched_pkg.sv
rtl/ctrl_msg_pkg.sv
rtl/host_cmd_regs.sv
rtl/ctrl_msg_decoder.sv
rtl/slot_keeper.sv
rtl/core_selector.sv
rtl/sched_top.sv
sim/tb_sched_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_sched_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
